// File: tb.f
+incdir+hdl
hdl/predictorPkg.sv
hdl/tableUpdateIf.sv
hdl/instructionAddressHashing.sv
hdl/patternHistoryTable.sv
hdl/branchTargetBuffer.sv
hdl/branchPredictor.sv
tb/branchPredictor_assert.sv
tb/tbBranchPredictor.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the branch predictor testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module tbBranchPredictor \
    -Mdir obj_dir \
    -f tb.f

# Keep the output even when the simulation exits with an error
output=$(./obj_dir/VtbBranchPredictor 2>&1) || true
echo "$output"

if grep -qF "*** TEST PASSED ***" <<< "$output"; then
    echo "Simulation passed"
    exit 0
fi

echo "Simulation failed"
exit 1

// File: tb/tbBranchPredictor.sv
// Testbench for the branch predictor, runs directed and seeded random lookups against a model
`timescale 1ns/1ps
`include "predictor_consts.svh"

module tbBranchPredictor;

    localparam int clockPeriod    = 40;
    localparam int resetCycles    = 5;
    localparam int entryCount     = 1 << `HASH_WIDTH;
    localparam int poolSize       = 12;
    localparam int randomCycles   = 2000;
    // Directed phases need well under this many cycles
    localparam int directedCycles = 200;
    localparam int timeoutCycles  = resetCycles + directedCycles + randomCycles + 100;

    logic                  clock;
    logic                  reset;
    logic                  predictValid;
    predictorPkg::addressT fetchAddress;
    logic                  updateValid;
    predictorPkg::addressT updateAddress;
    logic                  updateTaken;
    predictorPkg::addressT updateTarget;
    logic                  respValid;
    logic                  predictTaken;
    logic                  predictHit;
    predictorPkg::addressT predictTarget;

    integer seed = 32'h640052f9;

    // Mirror of both tables
    predictorPkg::counterT modelCounter [entryCount];
    logic                  modelValid   [entryCount];
    predictorPkg::addressT modelAddress [entryCount];
    predictorPkg::addressT modelTarget  [entryCount];

    // Expected response to the lookup driven one cycle earlier
    logic                  expResp;
    logic                  expHit;
    logic                  expTaken;
    predictorPkg::addressT expTarget;

    // Most recent response, used by the directed checks
    logic                  lastHit;
    logic                  lastTaken;
    predictorPkg::addressT lastTarget;

    predictorPkg::addressT pool [poolSize];

    branchPredictor i_branchPredictor (
        .clock         (clock),
        .reset         (reset),
        .predictValid  (predictValid),
        .fetchAddress  (fetchAddress),
        .updateValid   (updateValid),
        .updateAddress (updateAddress),
        .updateTaken   (updateTaken),
        .updateTarget  (updateTarget),
        .respValid     (respValid),
        .predictTaken  (predictTaken),
        .predictHit    (predictHit),
        .predictTarget (predictTarget)
    );

    initial begin
        clock = 1'b0;
        forever #(clockPeriod / 2) clock = ~clock;
    end

    initial begin : watchdog
        #(timeoutCycles * clockPeriod);
        abortRun($sformatf("Timeout: run did not finish within %0d cycles", timeoutCycles));
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "Run aborted");
    endtask

    task automatic checkValue(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
        if (actual !== expected) begin
            abortRun($sformatf("** Error: %s is 0x%0h, expected 0x%0h", name, actual, expected));
        end
    endtask

    // Index from the hash rule, written out from the byte and nibble sums
    function automatic predictorPkg::hashT hashAddress(input predictorPkg::addressT addr);
        predictorPkg::addressT lowMask;
        predictorPkg::addressT upperPart;
        logic [7:0]            byteSum;
        logic [3:0]            nibbleSum;
        int                    upperWidth;
        int                    upperBits;
        lowMask   = predictorPkg::addressT'((1 << `PRESERVED_BITS) - 1);
        upperPart = addr & ~lowMask;
        byteSum   = 8'd0;
        for (int b = 0; b < `ADDRESS_WIDTH / 8; b++) begin
            byteSum = byteSum + upperPart[8*b +: 8];
        end
        nibbleSum  = byteSum[7:4] + byteSum[3:0];
        upperWidth = `HASH_WIDTH - `PRESERVED_BITS;
        if (upperWidth < 5) begin
            upperBits = int'(nibbleSum);
        end else begin
            upperBits = int'(byteSum);
        end
        upperBits = upperBits & ((1 << upperWidth) - 1);
        return predictorPkg::hashT'((upperBits << `PRESERVED_BITS) | int'(addr & lowMask));
    endfunction

    // Different address with the same index, same low bits and random upper bits
    task automatic findAlias(input predictorPkg::addressT base,
                             output predictorPkg::addressT partner);
        predictorPkg::addressT lowMask;
        predictorPkg::addressT candidate;
        bit                    found;
        lowMask = predictorPkg::addressT'((1 << `PRESERVED_BITS) - 1);
        found   = 1'b0;
        partner = base;
        for (int i = 0; i < 1000 && !found; i++) begin
            candidate = (predictorPkg::addressT'($random(seed)) & ~lowMask) | (base & lowMask);
            if (candidate != base && hashAddress(candidate) == hashAddress(base)) begin
                partner = candidate;
                found   = 1'b1;
            end
        end
        if (!found) begin
            abortRun("Could not find a second address sharing a table entry");
        end
    endtask

    task automatic checkResponse();
        checkValue("respValid", 64'(respValid), 64'(expResp));
        if (expResp) begin
            checkValue("predictHit", 64'(predictHit), 64'(expHit));
            checkValue("predictTaken", 64'(predictTaken), 64'(expTaken));
            checkValue("predictTarget", 64'(predictTarget), 64'(expTarget));
            lastHit    = predictHit;
            lastTaken  = predictTaken;
            lastTarget = predictTarget;
        end
    endtask

    // One clock of stimulus; the response to the previous cycle is checked at the falling edge
    task automatic runCycle(input logic lookupValid, input predictorPkg::addressT lookupAddress,
                            input logic writeValid, input predictorPkg::addressT writeAddress,
                            input logic writeTaken, input predictorPkg::addressT writeTarget);
        predictorPkg::hashT    li;
        predictorPkg::hashT    ui;
        logic                  nextHit;
        logic                  nextTaken;
        predictorPkg::addressT nextTarget;
        @(posedge clock);
        predictValid  <= lookupValid;
        fetchAddress  <= lookupAddress;
        updateValid   <= writeValid;
        updateAddress <= writeAddress;
        updateTaken   <= writeTaken;
        updateTarget  <= writeTarget;
        // Read before write, so the expectation sees the state ahead of this update
        li         = hashAddress(lookupAddress);
        nextHit    = modelValid[li] && (modelAddress[li] == lookupAddress);
        nextTaken  = nextHit && modelCounter[li][1];
        nextTarget = nextTaken ? modelTarget[li]
                               : lookupAddress + predictorPkg::addressT'(`FETCH_STEP);
        if (writeValid) begin
            ui = hashAddress(writeAddress);
            if (writeTaken) begin
                if (modelCounter[ui] != 2'd3) begin
                    modelCounter[ui] = modelCounter[ui] + 2'd1;
                end
                modelValid[ui]   = 1'b1;
                modelAddress[ui] = writeAddress;
                modelTarget[ui]  = writeTarget;
            end else if (modelCounter[ui] != 2'd0) begin
                modelCounter[ui] = modelCounter[ui] - 2'd1;
            end
        end
        @(negedge clock);
        checkResponse();
        expResp   = lookupValid;
        expHit    = nextHit;
        expTaken  = nextTaken;
        expTarget = nextTarget;
    endtask

    // Lookup followed by an idle cycle so its response is in last*
    task automatic issueLookup(input predictorPkg::addressT addr);
        runCycle(1'b1, addr, 1'b0, '0, 1'b0, '0);
        runCycle(1'b0, '0, 1'b0, '0, 1'b0, '0);
    endtask

    task automatic trainBranch(input predictorPkg::addressT addr, input logic taken,
                               input predictorPkg::addressT target);
        runCycle(1'b0, '0, 1'b1, addr, taken, target);
    endtask

    initial begin : stimulus
        predictorPkg::addressT a;
        predictorPkg::addressT b;
        predictorPkg::addressT t;
        logic [3:0]            lookupPick;
        logic [3:0]            writePick;
        reset         = 1'b1;
        predictValid  = 1'b0;
        fetchAddress  = '0;
        updateValid   = 1'b0;
        updateAddress = '0;
        updateTaken   = 1'b0;
        updateTarget  = '0;
        expResp       = 1'b0;
        expHit        = 1'b0;
        expTaken      = 1'b0;
        expTarget     = '0;
        for (int i = 0; i < entryCount; i++) begin
            modelCounter[i] = `COUNTER_RESET;
            modelValid[i]   = 1'b0;
            modelAddress[i] = '0;
            modelTarget[i]  = '0;
        end
        repeat (resetCycles) @(posedge clock);
        reset <= 1'b0;

        // Empty buffer misses and falls through
        for (int i = 0; i < 20; i++) begin
            a = predictorPkg::addressT'($random(seed));
            issueLookup(a);
            checkValue("predictHit", 64'(lastHit), 64'd0);
            checkValue("predictTaken", 64'(lastTaken), 64'd0);
            checkValue("predictTarget", 64'(lastTarget),
                       64'(a + predictorPkg::addressT'(`FETCH_STEP)));
        end

        // Train up to strongly taken, then back down to strongly not taken
        a = predictorPkg::addressT'($random(seed));
        t = predictorPkg::addressT'($random(seed));
        repeat (3) trainBranch(a, 1'b1, t);
        issueLookup(a);
        checkValue("predictHit", 64'(lastHit), 64'd1);
        checkValue("predictTaken", 64'(lastTaken), 64'd1);
        checkValue("predictTarget", 64'(lastTarget), 64'(t));
        repeat (3) trainBranch(a, 1'b0, t);
        issueLookup(a);
        checkValue("predictHit", 64'(lastHit), 64'd1);
        checkValue("predictTaken", 64'(lastTaken), 64'd0);
        checkValue("predictTarget", 64'(lastTarget),
                   64'(a + predictorPkg::addressT'(`FETCH_STEP)));

        // Aliasing branch evicts the first one
        a = predictorPkg::addressT'($random(seed));
        findAlias(a, b);
        trainBranch(a, 1'b1, t);
        trainBranch(a, 1'b1, t);
        issueLookup(a);
        checkValue("predictHit", 64'(lastHit), 64'd1);
        trainBranch(b, 1'b1, ~t);
        issueLookup(a);
        checkValue("predictHit", 64'(lastHit), 64'd0);
        issueLookup(b);
        checkValue("predictHit", 64'(lastHit), 64'd1);

        // Same-cycle lookup and update see the old entry
        a = predictorPkg::addressT'($random(seed));
        t = predictorPkg::addressT'($random(seed));
        runCycle(1'b1, a, 1'b1, a, 1'b1, t);
        runCycle(1'b0, '0, 1'b0, '0, 1'b0, '0);
        checkValue("predictHit", 64'(lastHit), 64'd0);
        issueLookup(a);
        checkValue("predictHit", 64'(lastHit), 64'd1);

        // Small pool of address pairs that share entries
        for (int k = 0; k < poolSize / 2; k++) begin
            pool[2*k] = predictorPkg::addressT'($random(seed));
            findAlias(pool[2*k], pool[2*k+1]);
        end
        for (int i = 0; i < randomCycles; i++) begin
            lookupPick = 4'({$random(seed)} % poolSize);
            writePick  = 4'({$random(seed)} % poolSize);
            runCycle(($random(seed) & 3) != 0, pool[lookupPick],
                     ($random(seed) & 1) != 0, pool[writePick],
                     ($random(seed) & 1) != 0, predictorPkg::addressT'($random(seed)));
        end
        runCycle(1'b0, '0, 1'b0, '0, 1'b0, '0);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: tb/branchPredictor_assert.sv
// Protocol assertions for the branch predictor top level, attached by bind in the testbench build
`timescale 1ns/1ps

module branchPredictor_assert (
    input logic clock,
    input logic reset,
    input logic predictValid,
    input logic respValid,
    input logic predictTaken,
    input logic predictHit
);

    // Response strobe trails the request by exactly one cycle
    respFollowsRequest: assert property (
        @(posedge clock) !reset |=> (respValid == $past(predictValid))
    ) else $error("respValid did not follow predictValid by one cycle");

    // No response comes out of a reset cycle
    respQuietInReset: assert property (
        @(posedge clock) reset |=> !respValid
    ) else $error("respValid high after a reset cycle");

    // Taken needs a buffer hit to supply the target
    takenNeedsHit: assert property (
        @(posedge clock) disable iff (reset) predictTaken |-> predictHit
    ) else $error("predictTaken high without predictHit");

endmodule

bind branchPredictor branchPredictor_assert protocolChecks (
    .clock        (clock),
    .reset        (reset),
    .predictValid (predictValid),
    .respValid    (respValid),
    .predictTaken (predictTaken),
    .predictHit   (predictHit)
);

// File: hdl/branchPredictor.sv
// Branch predictor top level that hashes lookup and update addresses and forms the registered prediction
`timescale 1ns/1ps
`include "predictor_consts.svh"

module branchPredictor (
    input  logic                  clock,
    input  logic                  reset,

    // Lookup from fetch
    input  logic                  predictValid,
    input  predictorPkg::addressT fetchAddress,

    // Resolved branch from execute
    input  logic                  updateValid,
    input  predictorPkg::addressT updateAddress,
    input  logic                  updateTaken,
    input  predictorPkg::addressT updateTarget,

    // Prediction, one cycle after predictValid
    output logic                  respValid,
    output logic                  predictTaken,
    output logic                  predictHit,
    output predictorPkg::addressT predictTarget
);

    predictorPkg::hashT    lookupIndex;
    predictorPkg::hashT    updateIndex;
    predictorPkg::counterT counter;
    predictorPkg::addressT bufferTarget;
    predictorPkg::addressT fallThrough;
    logic                  bufferHit;

    tableUpdateIf tableUpdate ();

    instructionAddressHashing #(
        .dataBitWidth      (`ADDRESS_WIDTH),
        .preservedBitCount (`PRESERVED_BITS),
        .hashBitWidth      (`HASH_WIDTH)
    ) lookupHash (
        .instructionAddress (fetchAddress),
        .hashedAddress      (lookupIndex)
    );

    instructionAddressHashing #(
        .dataBitWidth      (`ADDRESS_WIDTH),
        .preservedBitCount (`PRESERVED_BITS),
        .hashBitWidth      (`HASH_WIDTH)
    ) updateHash (
        .instructionAddress (updateAddress),
        .hashedAddress      (updateIndex)
    );

    // Update bundle shared by both tables
    assign tableUpdate.valid   = updateValid;
    assign tableUpdate.index   = updateIndex;
    assign tableUpdate.taken   = updateTaken;
    assign tableUpdate.address = updateAddress;
    assign tableUpdate.target  = updateTarget;

    patternHistoryTable pht (
        .clock       (clock),
        .reset       (reset),
        .lookupIndex (lookupIndex),
        .update      (tableUpdate.tableSide),
        .counter     (counter)
    );

    branchTargetBuffer btb (
        .clock        (clock),
        .reset        (reset),
        .lookupIndex  (lookupIndex),
        .fetchAddress (fetchAddress),
        .update       (tableUpdate.tableSide),
        .hit          (bufferHit),
        .target       (bufferTarget)
    );

    always_ff @(posedge clock) begin
        if (reset) begin
            respValid <= 1'b0;
        end else begin
            respValid <= predictValid;
        end
    end

    // Kept alongside the table reads for a hit that predicts not taken
    always_ff @(posedge clock) begin
        fallThrough <= fetchAddress + predictorPkg::addressT'(`FETCH_STEP);
    end

    assign predictHit    = bufferHit;
    assign predictTaken  = bufferHit & counter[1];
    assign predictTarget = predictTaken ? bufferTarget : fallThrough;

endmodule

// File: hdl/branchTargetBuffer.sv
// Direct-mapped branch target buffer with a full address tag and registered hit and next-fetch target
`timescale 1ns/1ps
`include "predictor_consts.svh"

module branchTargetBuffer (
    input  logic                  clock,
    input  logic                  reset,
    input  predictorPkg::hashT    lookupIndex,
    input  predictorPkg::addressT fetchAddress,
    tableUpdateIf.tableSide       update,
    output logic                  hit,
    output predictorPkg::addressT target
);

    localparam int entryCount = 1 << `HASH_WIDTH;

    logic [entryCount-1:0] entryValid;
    predictorPkg::addressT entryAddress [entryCount];
    predictorPkg::addressT entryTarget  [entryCount];

    logic                  lookupHit;
    logic                  writeEnable;
    predictorPkg::addressT fallThrough;

    // Full address compare so aliasing branches never hit on each other
    assign lookupHit = entryValid[lookupIndex]
                       && (entryAddress[lookupIndex] == fetchAddress);

    assign fallThrough = fetchAddress + predictorPkg::addressT'(`FETCH_STEP);

    // Only taken branches allocate
    // A not-taken update leaves the entry as it was
    assign writeEnable = update.valid && update.taken;

    always_ff @(posedge clock) begin
        if (reset) begin
            entryValid <= '0;
            hit        <= 1'b0;
        end else begin
            hit <= lookupHit;
            if (writeEnable) begin
                entryValid[update.index] <= 1'b1;
            end
        end
    end

    // Tag and target storage plus the registered next-fetch address
    always_ff @(posedge clock) begin
        if (lookupHit) begin
            target <= entryTarget[lookupIndex];
        end else begin
            target <= fallThrough;
        end
        if (writeEnable) begin
            entryAddress[update.index] <= update.address;
            entryTarget[update.index]  <= update.target;
        end
    end

endmodule

// File: hdl/patternHistoryTable.sv
// Pattern history table of two-bit saturating counters with a registered lookup read and one update port
`timescale 1ns/1ps
`include "predictor_consts.svh"

module patternHistoryTable (
    input  logic                  clock,
    input  logic                  reset,
    input  predictorPkg::hashT    lookupIndex,
    tableUpdateIf.tableSide       update,
    output predictorPkg::counterT counter
);

    localparam int entryCount = 1 << `HASH_WIDTH;

    predictorPkg::counterT counters [entryCount];
    predictorPkg::counterT currentCount;
    predictorPkg::counterT trainedCount;

    assign currentCount = counters[update.index];

    // Saturating step toward the resolved direction
    always_comb begin
        trainedCount = currentCount;
        if (update.taken) begin
            if (currentCount != 2'd3) begin
                trainedCount = currentCount + 2'd1;
            end
        end else begin
            if (currentCount != 2'd0) begin
                trainedCount = currentCount - 2'd1;
            end
        end
    end

    // Registered read returns the value from before any same-cycle update
    always_ff @(posedge clock) begin
        counter <= counters[lookupIndex];
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < entryCount; i++) begin
                counters[i] <= `COUNTER_RESET;
            end
        end else if (update.valid) begin
            counters[update.index] <= trainedCount;
        end
    end

endmodule

// File: hdl/instructionAddressHashing.sv
// Combinational fold of an instruction address into a table index, instantiated for lookup and update
`timescale 1ns/1ps
`include "predictor_consts.svh"

module instructionAddressHashing #(
    // Supported address widths are 8, 16, 32 and 64
    parameter int dataBitWidth = `ADDRESS_WIDTH,
    // Must stay below hashBitWidth
    parameter int preservedBitCount = `PRESERVED_BITS,
    parameter int hashBitWidth = `HASH_WIDTH
) (
    input  logic [dataBitWidth-1:0] instructionAddress,
    output logic [hashBitWidth-1:0] hashedAddress
);

    localparam int hashInputBitWidth = dataBitWidth - preservedBitCount;
    localparam int localHashBitWidth = hashBitWidth - preservedBitCount;

    logic [preservedBitCount-1:0] preservedLowerBits;
    logic [hashInputBitWidth-1:0] hashedUpperBits;
    logic [dataBitWidth-1:0]      hashInput;
    logic [7:0]                   byteSum;
    logic [localHashBitWidth-1:0] upperHash;

    assign preservedLowerBits = instructionAddress[preservedBitCount-1:0];
    assign hashedUpperBits    = instructionAddress[dataBitWidth-1:preservedBitCount];

    // Preserved bits are zeroed in place so byte boundaries stay aligned
    assign hashInput = {hashedUpperBits, {preservedBitCount{1'b0}}};

    // Bytes summed modulo 256 as a balanced adder tree
    generate
        if (dataBitWidth == 8) begin : gSum8
            assign byteSum = hashInput;
        end else if (dataBitWidth == 16) begin : gSum16
            assign byteSum = hashInput[15:8] + hashInput[7:0];
        end else if (dataBitWidth == 32) begin : gSum32
            logic [7:0] lowPair;
            logic [7:0] highPair;

            assign lowPair  = hashInput[15:8] + hashInput[7:0];
            assign highPair = hashInput[31:24] + hashInput[23:16];
            assign byteSum  = highPair + lowPair;
        end else if (dataBitWidth == 64) begin : gSum64
            logic [7:0] pair0;
            logic [7:0] pair1;
            logic [7:0] pair2;
            logic [7:0] pair3;
            logic [7:0] lowHalf;
            logic [7:0] highHalf;

            assign pair0    = hashInput[15:8] + hashInput[7:0];
            assign pair1    = hashInput[31:24] + hashInput[23:16];
            assign pair2    = hashInput[47:40] + hashInput[39:32];
            assign pair3    = hashInput[63:56] + hashInput[55:48];
            assign lowHalf  = pair1 + pair0;
            assign highHalf = pair3 + pair2;
            assign byteSum  = highHalf + lowHalf;
        end
    endgenerate

    // Narrow upper fields fold the two nibbles first so every sum bit contributes
    generate
        if (localHashBitWidth < 5) begin : gNibbleFold
            logic [3:0] nibbleSum;

            assign nibbleSum = byteSum[7:4] + byteSum[3:0];
            assign upperHash = nibbleSum[localHashBitWidth-1:0];
        end else begin : gByteFold
            assign upperHash = localHashBitWidth'(byteSum);
        end
    endgenerate

    assign hashedAddress = {upperHash, preservedLowerBits};

endmodule

// File: hdl/tableUpdateIf.sv
// One resolved-branch write into the predictor tables, driven by the top and read by each table
`timescale 1ns/1ps

interface tableUpdateIf;

    // Write strobe, one per resolved branch
    logic valid;

    // Hashed branch address selecting the entry
    predictorPkg::hashT index;

    // Resolved direction
    logic taken;

    // Full branch address, kept as the buffer tag
    predictorPkg::addressT address;

    // Resolved branch target
    predictorPkg::addressT target;

    modport driver (
        output valid,
        output index,
        output taken,
        output address,
        output target
    );

    modport tableSide (
        input valid,
        input index,
        input taken,
        input address,
        input target
    );

endinterface

// File: hdl/predictorPkg.sv
// Address, index and counter types shared by the branch predictor RTL and its testbench
`include "predictor_consts.svh"

package predictorPkg;

    // Fetch, branch or target address
    typedef logic [`ADDRESS_WIDTH-1:0] addressT;

    // Index into either table
    typedef logic [`HASH_WIDTH-1:0] hashT;

    // Two-bit saturating counter
    // 0 and 1 predict not taken, 2 and 3 predict taken
    typedef logic [1:0] counterT;

endpackage

// File: hdl/predictor_consts.svh
// Width and reset-value macros for the branch predictor, included by RTL and testbench files
`ifndef PREDICTOR_CONSTS_SVH
`define PREDICTOR_CONSTS_SVH

// Instruction address width
// The hashing block also supports 8, 16 and 64
`define ADDRESS_WIDTH 32

// Low address bits copied straight into the table index
`define PRESERVED_BITS 3

// Table index width
// Six bits give 64 entries in each table
`define HASH_WIDTH 6

// Counter value after reset
// Weakly not taken, so one taken update flips the prediction
`define COUNTER_RESET 2'd1

// Fall-through increment for the next fetch address
`define FETCH_STEP 4

`endif
